// File: axi_lite_demux_golden.txt
# kind (W write, R read), select, address, write data or expected read data, expected resp
# all values hex, one transaction per line
W 0 00000000 11110000 0
W 1 00000004 22220001 0
W 2 00000008 33330002 2
W 3 0000000c 44440003 2
R 0 00000100 00000100 0
R 1 00000104 01000104 0
R 2 00000108 02000108 2
R 3 0000010c 0300010c 2
W 3 00000010 a5a50010 2
W 3 00000014 a5a50014 2
W 3 00000018 a5a50018 2
W 3 0000001c a5a5001c 2
W 3 00000020 a5a50020 2
W 3 00000024 a5a50024 2
R 3 00000200 03000200 2
R 3 00000204 03000204 2
R 0 00000208 00000208 0
W 0 00000030 0badf00d 0
R 2 1000020c 1200020c 2
W 1 00000034 cafe0034 0
R 1 20000210 21000210 0
W 2 00000038 deadbeef 2
R 3 30000214 33000214 2
W 0 0000003c 0000003c 0
R 0 40000218 40000218 0
W 1 00000040 ffffffff 0
R 1 80000230 81000230 0
W 2 00000044 12345678 2

// File: axi_lite_demux.f
axi_lite_demux_pkg.sv
select_fifo_if.sv
fifo_occupancy_counter.sv
select_fifo.sv
aw_lock_fsm.sv
write_route.sv
read_route.sv
axi_lite_demux.sv
tb_axi_lite_demux.sv

// File: Bender.yml
package:
  name: axi_lite_demux

sources:
  - axi_lite_demux_pkg.sv
  - select_fifo_if.sv
  - fifo_occupancy_counter.sv
  - select_fifo.sv
  - aw_lock_fsm.sv
  - write_route.sv
  - read_route.sv
  - axi_lite_demux.sv
  - target: test
    files:
      - tb_axi_lite_demux.sv

// File: tb_axi_lite_demux.sv
/*
 * testbench for the axi4-lite 1-to-4 demux
 * golden-file traffic against four randomly stalling slave models
 */
module tb_axi_lite_demux;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_lite_demux_pkg::*;

  localparam int    CLK_PERIOD  = 100;
  localparam string GOLDEN_FILE = "axi_lite_demux_golden.txt";

  logic      clk_i = 1'b0;
  logic      rst_i;
  // slave side, driven by the sequencer
  logic      slv_aw_valid_i, slv_aw_ready_o;
  logic      slv_w_valid_i, slv_w_ready_o;
  logic      slv_ar_valid_i, slv_ar_ready_o;
  logic      slv_b_valid_o, slv_r_valid_o;
  logic      slv_b_ready_i = 1'b0;
  logic      slv_r_ready_i = 1'b0;
  addr_t     slv_aw_addr_i, slv_ar_addr_i;
  prot_t     slv_aw_prot_i, slv_ar_prot_i;
  select_t   slv_aw_select_i, slv_ar_select_i;
  data_t     slv_w_data_i, slv_r_data_o;
  strb_t     slv_w_strb_i;
  resp_t     slv_b_resp_o, slv_r_resp_o;
  // master side, driven by the slave models
  port_vec_t mst_aw_valid_o, mst_w_valid_o, mst_b_ready_o, mst_ar_valid_o, mst_r_ready_o;
  port_vec_t mst_aw_ready_i = '0;
  port_vec_t mst_w_ready_i  = '0;
  port_vec_t mst_b_valid_i  = '0;
  port_vec_t mst_ar_ready_i = '0;
  port_vec_t mst_r_valid_i  = '0;
  addr_t     mst_aw_addr_o, mst_ar_addr_o;
  prot_t     mst_aw_prot_o, mst_ar_prot_o;
  data_t     mst_w_data_o;
  strb_t     mst_w_strb_o;
  resp_t [NO_MST_PORTS-1:0] mst_b_resp_i = '0;
  resp_t [NO_MST_PORTS-1:0] mst_r_resp_i = '0;
  data_t [NO_MST_PORTS-1:0] mst_r_data_i = '0;

  // golden transactions, split by direction
  select_t wr_sel [$];
  addr_t   wr_addr [$];
  data_t   wr_data [$];
  resp_t   wr_resp [$];
  select_t rd_sel [$];
  addr_t   rd_addr [$];
  data_t   rd_data [$];
  resp_t   rd_resp [$];
  int      n_lines;
  logic    golden_loaded = 1'b0;

  // slave model state
  logic [31:0]              rng_state = 32'd83;
  addr_t                    aw_rec_q [NO_MST_PORTS][$];
  prot_t                    aw_prot_q [NO_MST_PORTS][$];
  logic [STRB_W+DATA_W-1:0] w_rec_q [NO_MST_PORTS][$];
  addr_t                    ar_rec_q [NO_MST_PORTS][$];
  prot_t                    ar_prot_q [NO_MST_PORTS][$];
  int                       aw_cnt [NO_MST_PORTS];
  int                       w_cnt [NO_MST_PORTS];
  int                       b_cnt [NO_MST_PORTS];
  int                       ar_cnt [NO_MST_PORTS];
  int                       slv_aw_hs, slv_w_hs, slv_b_hs;

  axi_lite_demux u_dut (.*);

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // low ports answer OKAY, high ports SLVERR
  function automatic resp_t port_resp(input int p);
    return (p >= 2) ? 2'b10 : 2'b00;
  endfunction

  // strobe pattern per write, never all zero
  function automatic strb_t strobe_of(input int idx);
    return {1'b1, 3'(idx)};
  endfunction

  // prot pattern per request, reads inverted to tell the channels apart
  function automatic prot_t prot_of(input int idx, input logic rd);
    return rd ? ~prot_t'(idx) : prot_t'(idx);
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR @ %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  task automatic load_golden();
    int         fd;
    int         n;
    string      line;
    logic [7:0] kind;
    select_t    sel;
    addr_t      addr;
    data_t      data;
    resp_t      resp;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the golden stimulus file %s", GOLDEN_FILE);
      $display("Test failures found");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // comment and blank lines carry no transaction
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%c %h %h %h %h", kind, sel, addr, data, resp);
        if (n == 5 && kind == "W") begin
          wr_sel.push_back(sel);
          wr_addr.push_back(addr);
          wr_data.push_back(data);
          wr_resp.push_back(resp);
        end else if (n == 5 && kind == "R") begin
          rd_sel.push_back(sel);
          rd_addr.push_back(addr);
          rd_data.push_back(data);
          rd_resp.push_back(resp);
        end
      end
    end
    $fclose(fd);
    n_lines       = wr_sel.size() + rd_sel.size();
    golden_loaded = 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // slave-side drivers and response collectors
  // ----------------------------------------------------------------------
  task automatic issue_aw();
    for (int i = 0; i < wr_sel.size(); i++) begin
      slv_aw_valid_i  <= 1'b1;
      slv_aw_addr_i   <= wr_addr[i];
      slv_aw_prot_i   <= prot_of(i, 1'b0);
      slv_aw_select_i <= wr_sel[i];
      @(posedge clk_i);
      while (!slv_aw_ready_o) @(posedge clk_i);
    end
    slv_aw_valid_i <= 1'b0;
  endtask

  task automatic issue_w();
    for (int i = 0; i < wr_sel.size(); i++) begin
      slv_w_valid_i <= 1'b1;
      slv_w_data_i  <= wr_data[i];
      slv_w_strb_i  <= strobe_of(i);
      @(posedge clk_i);
      while (!slv_w_ready_o) @(posedge clk_i);
    end
    slv_w_valid_i <= 1'b0;
  endtask

  task automatic issue_ar();
    for (int i = 0; i < rd_sel.size(); i++) begin
      slv_ar_valid_i  <= 1'b1;
      slv_ar_addr_i   <= rd_addr[i];
      slv_ar_prot_i   <= prot_of(i, 1'b1);
      slv_ar_select_i <= rd_sel[i];
      @(posedge clk_i);
      while (!slv_ar_ready_o) @(posedge clk_i);
    end
    slv_ar_valid_i <= 1'b0;
  endtask

  task automatic collect_b();
    int                       p;
    addr_t                    addr;
    prot_t                    prot;
    logic [STRB_W+DATA_W-1:0] beat;
    for (int i = 0; i < wr_sel.size(); i++) begin
      @(posedge clk_i);
      while (!(slv_b_valid_o && slv_b_ready_i)) @(posedge clk_i);
      p = wr_sel[i];
      check_value(32'(slv_b_resp_o), 32'(wr_resp[i]), "B response in AW order");
      // target port must hold this write, and no other port
      check_value(32'(aw_rec_q[p].size() > 0 && w_rec_q[p].size() > 0), 32'd1,
                  "write seen at selected port");
      addr = aw_rec_q[p].pop_front();
      prot = aw_prot_q[p].pop_front();
      beat = w_rec_q[p].pop_front();
      check_value(addr, wr_addr[i], "AW address at port");
      check_value(32'(prot), 32'(prot_of(i, 1'b0)), "AW prot at port");
      check_value(beat[DATA_W-1:0], wr_data[i], "W data recorded at port");
      check_value(32'(beat[DATA_W+:STRB_W]), 32'(strobe_of(i)), "W strobe at port");
    end
  endtask

  task automatic collect_r();
    int    p;
    prot_t prot;
    for (int i = 0; i < rd_sel.size(); i++) begin
      @(posedge clk_i);
      while (!(slv_r_valid_o && slv_r_ready_i)) @(posedge clk_i);
      p = rd_sel[i];
      check_value(slv_r_data_o, rd_data[i], "R data in AR order");
      check_value(32'(slv_r_resp_o), 32'(rd_resp[i]), "R response in AR order");
      check_value(32'(ar_prot_q[p].size() > 0), 32'd1, "read seen at selected port");
      prot = ar_prot_q[p].pop_front();
      check_value(32'(prot), 32'(prot_of(i, 1'b1)), "AR prot at port");
    end
  endtask

  // ----------------------------------------------------------------------
  // four slave models, one random draw process
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic [31:0] rnd;
    int          pend;
    if (rst_i) begin
      mst_aw_ready_i <= '0;
      mst_w_ready_i  <= '0;
      mst_b_valid_i  <= '0;
      mst_ar_ready_i <= '0;
      mst_r_valid_i  <= '0;
      slv_b_ready_i  <= 1'b0;
      slv_r_ready_i  <= 1'b0;
    end else begin
      check_value(32'($onehot0(mst_aw_valid_o)), 32'd1, "AW valid one-hot");
      check_value(32'($onehot0(mst_w_valid_o)), 32'd1, "W valid one-hot");
      check_value(32'($onehot0(mst_ar_valid_o)), 32'd1, "AR valid one-hot");
      // response ready only towards the head port
      check_value(32'($onehot0(mst_b_ready_o)), 32'd1, "B ready one-hot");
      check_value(32'($onehot0(mst_r_ready_o)), 32'd1, "R ready one-hot");
      if (slv_aw_valid_i && slv_aw_ready_o) slv_aw_hs++;
      if (slv_w_valid_i && slv_w_ready_o) slv_w_hs++;
      if (slv_b_valid_o && slv_b_ready_i) slv_b_hs++;
      // open writes bounded per ordering stage
      check_value(32'((slv_aw_hs - slv_w_hs) <= int'(MAX_TRANS)), 32'd1, "writes awaiting W");
      check_value(32'((slv_w_hs - slv_b_hs) <= int'(MAX_TRANS)), 32'd1, "writes awaiting B");
      for (int p = 0; p < NO_MST_PORTS; p++) begin
        rng_state = xorshift32(rng_state);
        rnd       = rng_state;
        if (mst_aw_valid_o[p] && mst_aw_ready_i[p]) begin
          aw_rec_q[p].push_back(mst_aw_addr_o);
          aw_prot_q[p].push_back(mst_aw_prot_o);
          aw_cnt[p]++;
        end
        // W may arrive before its AW at this port
        if (mst_w_valid_o[p] && mst_w_ready_i[p]) begin
          w_rec_q[p].push_back({mst_w_strb_o, mst_w_data_o});
          w_cnt[p]++;
        end
        if (mst_b_valid_i[p] && mst_b_ready_o[p]) b_cnt[p]++;
        if (mst_ar_valid_o[p] && mst_ar_ready_i[p]) begin
          ar_rec_q[p].push_back(mst_ar_addr_o);
          ar_prot_q[p].push_back(mst_ar_prot_o);
          ar_cnt[p]++;
        end
        if (mst_r_valid_i[p] && mst_r_ready_o[p]) void'(ar_rec_q[p].pop_front());
        // B once both halves are in, held until taken
        pend = ((aw_cnt[p] < w_cnt[p]) ? aw_cnt[p] : w_cnt[p]) - b_cnt[p];
        if (!(mst_b_valid_i[p] && !mst_b_ready_o[p])) begin
          mst_b_valid_i[p] <= (pend > 0) && rnd[3];
          mst_b_resp_i[p]  <= port_resp(p);
        end
        // read data is port index in the top byte, xor address
        if (!(mst_r_valid_i[p] && !mst_r_ready_o[p])) begin
          mst_r_valid_i[p] <= (ar_rec_q[p].size() > 0) && rnd[4];
          if (ar_rec_q[p].size() > 0) begin
            mst_r_data_i[p] <= ar_rec_q[p][0] ^ (addr_t'(p) << 24);
          end
          mst_r_resp_i[p] <= port_resp(p);
        end
        // port 3 accepts AW rarely
        mst_aw_ready_i[p] <= (p == 3) ? (rnd[7:5] == 3'b000) : rnd[0];
        mst_w_ready_i[p]  <= rnd[1];
        mst_ar_ready_i[p] <= rnd[2];
      end
      rng_state = xorshift32(rng_state);
      slv_b_ready_i <= rng_state[0];
      slv_r_ready_i <= rng_state[1] | rng_state[2];
    end
  end

  // ----------------------------------------------------------------------
  // sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    int exp_aw;
    int exp_ar;
    rst_i           = 1'b1;
    slv_aw_valid_i  = 1'b0;
    slv_aw_addr_i   = '0;
    slv_aw_prot_i   = '0;
    slv_aw_select_i = '0;
    slv_w_valid_i   = 1'b0;
    slv_w_data_i    = '0;
    slv_w_strb_i    = '0;
    slv_ar_valid_i  = 1'b0;
    slv_ar_addr_i   = '0;
    slv_ar_prot_i   = '0;
    slv_ar_select_i = '0;
    load_golden();
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    // quiet outputs before the first request
    repeat (3) begin
      @(posedge clk_i);
      check_value(32'(mst_aw_valid_o | mst_w_valid_o | mst_ar_valid_o), 32'd0, "idle valids");
      check_value(32'({slv_b_valid_o, slv_r_valid_o}), 32'd0, "idle responses");
      check_value(32'(mst_b_ready_o | mst_r_ready_o), 32'd0, "idle response readies");
    end
    fork
      issue_aw();
      issue_w();
      issue_ar();
      collect_b();
      collect_r();
    join
    repeat (4) @(posedge clk_i);
    // each request delivered exactly once
    for (int p = 0; p < NO_MST_PORTS; p++) begin
      exp_aw = 0;
      exp_ar = 0;
      foreach (wr_sel[i]) exp_aw += (wr_sel[i] == p);
      foreach (rd_sel[i]) exp_ar += (rd_sel[i] == p);
      check_value(aw_cnt[p], exp_aw, "AW handshakes per port");
      check_value(w_cnt[p], exp_aw, "W handshakes per port");
      check_value(ar_cnt[p], exp_ar, "AR handshakes per port");
      check_value(32'(w_rec_q[p].size()), 32'd0, "unclaimed W beats");
    end
    $display("All tests passed!");
    $finish;
  end

  initial begin
    wait (golden_loaded);
    repeat (200 * n_lines + 20) @(posedge clk_i);
    $display("timeout, golden traffic did not complete in time");
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: axi_lite_demux.sv
/*
 * axi4-lite 1-to-4 demux, slave port steered to four master ports
 * responses returned in request order through select fifos
 */
module axi_lite_demux (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // slave AW
  input  logic                          slv_aw_valid_i,
  input  axi_lite_demux_pkg::addr_t     slv_aw_addr_i,
  input  axi_lite_demux_pkg::prot_t     slv_aw_prot_i,
  input  axi_lite_demux_pkg::select_t   slv_aw_select_i,
  output logic                          slv_aw_ready_o,
  // slave W
  input  logic                          slv_w_valid_i,
  input  axi_lite_demux_pkg::data_t     slv_w_data_i,
  input  axi_lite_demux_pkg::strb_t     slv_w_strb_i,
  output logic                          slv_w_ready_o,
  // slave B
  output logic                          slv_b_valid_o,
  output axi_lite_demux_pkg::resp_t     slv_b_resp_o,
  input  logic                          slv_b_ready_i,
  // slave AR
  input  logic                          slv_ar_valid_i,
  input  axi_lite_demux_pkg::addr_t     slv_ar_addr_i,
  input  axi_lite_demux_pkg::prot_t     slv_ar_prot_i,
  input  axi_lite_demux_pkg::select_t   slv_ar_select_i,
  output logic                          slv_ar_ready_o,
  // slave R
  output logic                          slv_r_valid_o,
  output axi_lite_demux_pkg::data_t     slv_r_data_o,
  output axi_lite_demux_pkg::resp_t     slv_r_resp_o,
  input  logic                          slv_r_ready_i,
  // master side, payloads broadcast
  output axi_lite_demux_pkg::port_vec_t mst_aw_valid_o,
  output axi_lite_demux_pkg::addr_t     mst_aw_addr_o,
  output axi_lite_demux_pkg::prot_t     mst_aw_prot_o,
  input  axi_lite_demux_pkg::port_vec_t mst_aw_ready_i,
  output axi_lite_demux_pkg::port_vec_t mst_w_valid_o,
  output axi_lite_demux_pkg::data_t     mst_w_data_o,
  output axi_lite_demux_pkg::strb_t     mst_w_strb_o,
  input  axi_lite_demux_pkg::port_vec_t mst_w_ready_i,
  input  axi_lite_demux_pkg::port_vec_t mst_b_valid_i,
  input  axi_lite_demux_pkg::resp_t [axi_lite_demux_pkg::NO_MST_PORTS-1:0] mst_b_resp_i,
  output axi_lite_demux_pkg::port_vec_t mst_b_ready_o,
  output axi_lite_demux_pkg::port_vec_t mst_ar_valid_o,
  output axi_lite_demux_pkg::addr_t     mst_ar_addr_o,
  output axi_lite_demux_pkg::prot_t     mst_ar_prot_o,
  input  axi_lite_demux_pkg::port_vec_t mst_ar_ready_i,
  input  axi_lite_demux_pkg::port_vec_t mst_r_valid_i,
  input  axi_lite_demux_pkg::data_t [axi_lite_demux_pkg::NO_MST_PORTS-1:0] mst_r_data_i,
  input  axi_lite_demux_pkg::resp_t [axi_lite_demux_pkg::NO_MST_PORTS-1:0] mst_r_resp_i,
  output axi_lite_demux_pkg::port_vec_t mst_r_ready_o
);

  // ordering fifos, aw to w, w to b, ar to r
  select_fifo_if w_fifo ();
  select_fifo_if b_fifo ();
  select_fifo_if r_fifo ();

  // request payloads go to every port, valid picks the target
  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_aw_prot_o = slv_aw_prot_i;
  assign mst_w_data_o  = slv_w_data_i;
  assign mst_w_strb_o  = slv_w_strb_i;
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_ar_prot_o = slv_ar_prot_i;

  // ----------------------------------------------------------------------
  // write path
  // ----------------------------------------------------------------------
  aw_lock_fsm u_aw_lock (
    .clk_i, .rst_i,
    .aw_valid_i     (slv_aw_valid_i),
    .aw_select_i    (slv_aw_select_i),
    .aw_ready_o     (slv_aw_ready_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .w_fifo         (w_fifo.producer)
  );

  select_fifo u_w_fifo (.clk_i, .rst_i, .q(w_fifo.fifo));
  select_fifo u_b_fifo (.clk_i, .rst_i, .q(b_fifo.fifo));

  write_route u_write_route (
    .clk_i, .rst_i,
    .w_valid_i     (slv_w_valid_i),
    .w_ready_o     (slv_w_ready_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_resp_i  (mst_b_resp_i),
    .mst_b_ready_o (mst_b_ready_o),
    .b_valid_o     (slv_b_valid_o),
    .b_resp_o      (slv_b_resp_o),
    .b_ready_i     (slv_b_ready_i),
    .w_fifo        (w_fifo.consumer),
    .b_fifo_in     (b_fifo.producer),
    .b_fifo_out    (b_fifo.consumer)
  );

  // ----------------------------------------------------------------------
  // read path
  // ----------------------------------------------------------------------
  select_fifo u_r_fifo (.clk_i, .rst_i, .q(r_fifo.fifo));

  read_route u_read_route (
    .clk_i, .rst_i,
    .ar_valid_i     (slv_ar_valid_i),
    .ar_select_i    (slv_ar_select_i),
    .ar_ready_o     (slv_ar_ready_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_data_i   (mst_r_data_i),
    .mst_r_resp_i   (mst_r_resp_i),
    .mst_r_ready_o  (mst_r_ready_o),
    .r_valid_o      (slv_r_valid_o),
    .r_data_o       (slv_r_data_o),
    .r_resp_o       (slv_r_resp_o),
    .r_ready_i      (slv_r_ready_i),
    .r_fifo_in      (r_fifo.producer),
    .r_fifo_out     (r_fifo.consumer)
  );

endmodule

// File: read_route.sv
/*
 * read request and response routing
 * AR steered by its select, R returned in AR order
 */
module read_route (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          ar_valid_i,
  input  axi_lite_demux_pkg::select_t   ar_select_i,
  output logic                          ar_ready_o,
  output axi_lite_demux_pkg::port_vec_t mst_ar_valid_o,
  input  axi_lite_demux_pkg::port_vec_t mst_ar_ready_i,
  input  axi_lite_demux_pkg::port_vec_t mst_r_valid_i,
  input  axi_lite_demux_pkg::data_t [axi_lite_demux_pkg::NO_MST_PORTS-1:0] mst_r_data_i,
  input  axi_lite_demux_pkg::resp_t [axi_lite_demux_pkg::NO_MST_PORTS-1:0] mst_r_resp_i,
  output axi_lite_demux_pkg::port_vec_t mst_r_ready_o,
  output logic                          r_valid_o,
  output axi_lite_demux_pkg::data_t     r_data_o,
  output axi_lite_demux_pkg::resp_t     r_resp_o,
  input  logic                          r_ready_i,
  select_fifo_if.producer               r_fifo_in,
  select_fifo_if.consumer               r_fifo_out
);
  import axi_lite_demux_pkg::*;

  // ----------------------------------------------------------------------
  // AR channel
  // ----------------------------------------------------------------------
  // held back while no room for the select
  always_comb begin
    mst_ar_valid_o              = '0;
    mst_ar_valid_o[ar_select_i] = ar_valid_i && !r_fifo_in.full;
  end

  assign ar_ready_o       = !r_fifo_in.full && mst_ar_ready_i[ar_select_i];
  assign r_fifo_in.push   = ar_valid_i && ar_ready_o;
  assign r_fifo_in.wr_sel = ar_select_i;

  // ----------------------------------------------------------------------
  // R channel
  // ----------------------------------------------------------------------
  assign r_valid_o = !r_fifo_out.empty && mst_r_valid_i[r_fifo_out.rd_sel];
  assign r_data_o  = r_fifo_out.empty ? '0 : mst_r_data_i[r_fifo_out.rd_sel];
  assign r_resp_o  = r_fifo_out.empty ? '0 : mst_r_resp_i[r_fifo_out.rd_sel];

  always_comb begin
    mst_r_ready_o                    = '0;
    mst_r_ready_o[r_fifo_out.rd_sel] = !r_fifo_out.empty && r_ready_i;
  end

  assign r_fifo_out.pop = r_valid_o && r_ready_i;

  // upstream keeps the request and its target until accepted
  a_ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (ar_valid_i && !ar_ready_o) |=> (ar_valid_i && $stable(ar_select_i)));

endmodule

// File: write_route.sv
/*
 * write data and response routing
 * W follows the w fifo head, B returns in the order of W beats
 */
module write_route (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          w_valid_i,
  output logic                          w_ready_o,
  output axi_lite_demux_pkg::port_vec_t mst_w_valid_o,
  input  axi_lite_demux_pkg::port_vec_t mst_w_ready_i,
  input  axi_lite_demux_pkg::port_vec_t mst_b_valid_i,
  input  axi_lite_demux_pkg::resp_t [axi_lite_demux_pkg::NO_MST_PORTS-1:0] mst_b_resp_i,
  output axi_lite_demux_pkg::port_vec_t mst_b_ready_o,
  output logic                          b_valid_o,
  output axi_lite_demux_pkg::resp_t     b_resp_o,
  input  logic                          b_ready_i,
  select_fifo_if.consumer               w_fifo,
  select_fifo_if.producer               b_fifo_in,
  select_fifo_if.consumer               b_fifo_out
);
  import axi_lite_demux_pkg::*;

  logic w_open;
  logic w_fire;

  // ----------------------------------------------------------------------
  // W channel
  // ----------------------------------------------------------------------
  // needs a known target and room for its B select
  assign w_open = !w_fifo.empty && !b_fifo_in.full;

  always_comb begin
    mst_w_valid_o                = '0;
    mst_w_valid_o[w_fifo.rd_sel] = w_open && w_valid_i;
  end

  assign w_ready_o = w_open && mst_w_ready_i[w_fifo.rd_sel];
  assign w_fire    = w_valid_i && w_ready_o;

  // beat done, select moves from w fifo to b fifo
  assign w_fifo.pop       = w_fire;
  assign b_fifo_in.push   = w_fire;
  assign b_fifo_in.wr_sel = w_fifo.rd_sel;

  // ----------------------------------------------------------------------
  // B channel
  // ----------------------------------------------------------------------
  assign b_valid_o = !b_fifo_out.empty && mst_b_valid_i[b_fifo_out.rd_sel];
  assign b_resp_o  = b_fifo_out.empty ? '0 : mst_b_resp_i[b_fifo_out.rd_sel];

  // only the head port gets ready
  always_comb begin
    mst_b_ready_o                    = '0;
    mst_b_ready_o[b_fifo_out.rd_sel] = !b_fifo_out.empty && b_ready_i;
  end

  assign b_fifo_out.pop = b_valid_o && b_ready_i;

  // a stalled beat stays at its port until taken
  a_w_valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
    |(mst_w_valid_o & ~mst_w_ready_i) |=> $stable(mst_w_valid_o));

endmodule

// File: aw_lock_fsm.sv
/*
 * aw issue control, steers AW to the selected master port
 * select is pushed once, valid held under master stall
 */
module aw_lock_fsm (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          aw_valid_i,
  input  axi_lite_demux_pkg::select_t   aw_select_i,
  output logic                          aw_ready_o,
  output axi_lite_demux_pkg::port_vec_t mst_aw_valid_o,
  input  axi_lite_demux_pkg::port_vec_t mst_aw_ready_i,
  select_fifo_if.producer               w_fifo
);
  import axi_lite_demux_pkg::*;

  // IDLE waits for a new AW, LOCKED means select already pushed
  enum logic {IDLE, LOCKED} state_q, state_d;

  assign w_fifo.wr_sel = aw_select_i;

  always_comb begin
    state_d        = state_q;
    aw_ready_o     = 1'b0;
    mst_aw_valid_o = '0;
    w_fifo.push    = 1'b0;
    case (state_q)
      IDLE: begin
        // valid only raised when the w fifo can take the select
        if (aw_valid_i && !w_fifo.full) begin
          w_fifo.push                 = 1'b1;
          mst_aw_valid_o[aw_select_i] = 1'b1;
          if (mst_aw_ready_i[aw_select_i]) begin
            aw_ready_o = 1'b1;
          end else begin
            state_d = LOCKED;
          end
        end
      end
      LOCKED: begin
        // keep the request up, no second push
        mst_aw_valid_o[aw_select_i] = 1'b1;
        if (mst_aw_ready_i[aw_select_i]) begin
          aw_ready_o = 1'b1;
          state_d    = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // a stalled master sees the same valid next cycle
  a_aw_valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
    |(mst_aw_valid_o & ~mst_aw_ready_i) |=> $stable(mst_aw_valid_o));
  // the pushed select must match the port still being driven
  a_sel_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == LOCKED) |-> $stable(aw_select_i));

endmodule

// File: select_fifo.sv
/*
 * select fifo, MAX_TRANS port indices in order of arrival
 * no fall-through, a push shows at rd_sel one cycle later
 */
module select_fifo (
  input  logic        clk_i,
  input  logic        rst_i,
  select_fifo_if.fifo q
);
  import axi_lite_demux_pkg::*;

  logic [$clog2(MAX_TRANS)-1:0] wr_ptr;
  logic [$clog2(MAX_TRANS)-1:0] rd_ptr;
  // select storage
  select_t                      mem_q [MAX_TRANS];

  // ----------------------------------------------------------------------
  // pointers and flags
  // ----------------------------------------------------------------------
  fifo_occupancy_counter u_occupancy (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .push_i   (q.push),
    .pop_i    (q.pop),
    .wr_ptr_o (wr_ptr),
    .rd_ptr_o (rd_ptr),
    .full_o   (q.full),
    .empty_o  (q.empty)
  );

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (q.push) begin
      mem_q[wr_ptr] <= q.wr_sel;
    end
  end

  // head entry, only meaningful while not empty
  assign q.rd_sel = mem_q[rd_ptr];

endmodule

// File: fifo_occupancy_counter.sv
/*
 * occupancy tracking of one select fifo
 * wrapping read and write pointers plus a fill count
 */
module fifo_occupancy_counter (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  input  logic                                             push_i,
  input  logic                                             pop_i,
  output logic [$clog2(axi_lite_demux_pkg::MAX_TRANS)-1:0] wr_ptr_o,
  output logic [$clog2(axi_lite_demux_pkg::MAX_TRANS)-1:0] rd_ptr_o,
  output logic                                             full_o,
  output logic                                             empty_o
);
  import axi_lite_demux_pkg::*;

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_o <= '0;
      rd_ptr_o <= '0;
      cnt_q    <= '0;
    end else begin
      // pointers wrap at the last entry
      if (push_i) begin
        wr_ptr_o <= ({1'b0, wr_ptr_o} == CNT_W'(MAX_TRANS - 1)) ? '0 : wr_ptr_o + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_o <= ({1'b0, rd_ptr_o} == CNT_W'(MAX_TRANS - 1)) ? '0 : rd_ptr_o + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign full_o  = (cnt_q == CNT_W'(MAX_TRANS));
  assign empty_o = (cnt_q == '0);

  // producers and consumers must respect the flags
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) full_o |-> !push_i);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i) empty_o |-> !pop_i);

endmodule

// File: select_fifo_if.sv
/*
 * select fifo bundle, push and pop side of one ordering fifo
 */
interface select_fifo_if;
  import axi_lite_demux_pkg::*;

  // write side
  logic    push;
  select_t wr_sel;
  logic    full;
  // read side
  logic    pop;
  select_t rd_sel;
  logic    empty;

  // push only while full is low
  modport producer (output push, output wr_sel, input full);
  // pop only while empty is low
  modport consumer (output pop, input rd_sel, input empty);
  // storage view
  modport fifo (
    input  push,
    input  wr_sel,
    input  pop,
    output rd_sel,
    output full,
    output empty
  );

endinterface

// File: axi_lite_demux_pkg.sv
/*
 * shared definitions of the 1-to-4 axi4-lite demux
 * port count, ordering depth and channel field types
 */
package axi_lite_demux_pkg;

  // ----------------------------------------------------------------------
  // structure
  // ----------------------------------------------------------------------
  // number of master ports
  localparam int unsigned NO_MST_PORTS = 4;
  // bits needed to name one master port
  localparam int unsigned SEL_W = 2;
  // open transactions per direction, depth of each select fifo
  localparam int unsigned MAX_TRANS = 4;
  // fill count has to reach MAX_TRANS itself
  localparam int unsigned CNT_W = 3;

  // ----------------------------------------------------------------------
  // channel widths
  // ----------------------------------------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  // one strobe bit per data byte
  localparam int unsigned STRB_W = 4;

  // master port index, carried through the select fifos
  typedef logic [SEL_W-1:0] select_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  // axi prot field
  typedef logic [2:0] prot_t;
  // okay, exokay, slverr, decerr
  typedef logic [1:0] resp_t;
  // one valid or ready bit per master port
  typedef logic [NO_MST_PORTS-1:0] port_vec_t;

endpackage
